/* Makefile */
VERILATOR  ?= verilator
TOP        := mem_reg_file_tb
RTL_TOP    := mem_reg_file_top
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_TEXT  := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
src/mem_reg_pkg.sv
src/axil_slave_port.sv
src/bw_token_regs.sv
src/decouple_ctrl_regs.sv
src/mem_reg_file_top.sv
verification/mem_reg_file_tb.sv

/* src/axil_slave_port.sv */
`timescale 1ns/1ns
`default_nettype none

module axil_slave_port #(
    parameter int AXIL_ADDR_WIDTH = 10
) (
    input  logic                                           aclk,
    input  logic                                           aresetn,

    input  logic [AXIL_ADDR_WIDTH-1:0]                     awaddr,
    input  logic                                           awvalid,
    output logic                                           awready,
    input  logic [mem_reg_pkg::AXIL_DATA_WIDTH-1:0]        wdata,
    input  logic                                           wvalid,
    output logic                                           wready,
    output logic                                           bvalid,
    output logic [1:0]                                     bresp,
    input  logic                                           bready,

    input  logic [AXIL_ADDR_WIDTH-1:0]                     araddr,
    input  logic                                           arvalid,
    output logic                                           arready,
    output logic                                           rvalid,
    output logic [1:0]                                     rresp,
    output logic [mem_reg_pkg::AXIL_DATA_WIDTH-1:0]        rdata,
    input  logic                                           rready,

    output logic                                           wr_en,
    output logic [AXIL_ADDR_WIDTH-mem_reg_pkg::ADDR_LSB-1:0] wr_word,
    output logic [mem_reg_pkg::AXIL_DATA_WIDTH-1:0]        wr_data,
    output logic [AXIL_ADDR_WIDTH-mem_reg_pkg::ADDR_LSB-1:0] rd_word,
    input  logic [mem_reg_pkg::AXIL_DATA_WIDTH-1:0]        rd_data
);
    import mem_reg_pkg::*;

    localparam int WORD_WIDTH = AXIL_ADDR_WIDTH - ADDR_LSB;

    wr_state_e                  wr_state;
    logic                       wr_start;
    logic                       ar_start;
    logic [AXIL_ADDR_WIDTH-1:0] awaddr_q;
    logic [AXIL_ADDR_WIDTH-1:0] araddr_q;

    // Address and data must both be offered before anything is accepted
    assign wr_start = (wr_state == WR_IDLE) && awvalid && wvalid && !bvalid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_state <= WR_IDLE;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    if (wr_start) begin
                        wr_state <= WR_ACCEPT;
                    end
                end
                // Master gave up during the ready cycle, drop the write
                WR_ACCEPT: begin
                    if (awvalid && wvalid) begin
                        wr_state <= WR_RESP;
                    end else begin
                        wr_state <= WR_IDLE;
                    end
                end
                WR_RESP: begin
                    if (bready) begin
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_start) begin
            awaddr_q <= awaddr;
        end
    end

    assign awready = (wr_state == WR_ACCEPT);
    assign wready  = (wr_state == WR_ACCEPT);
    assign bvalid  = (wr_state == WR_RESP);
    assign bresp   = RESP_OKAY;

    // Register strobe during the single ready cycle
    assign wr_en   = awready && awvalid && wready && wvalid;
    assign wr_word = awaddr_q[ADDR_LSB +: WORD_WIDTH];
    assign wr_data = wdata;

    // Read channel, one outstanding read at a time
    assign ar_start = arvalid && !arready && !rvalid;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= ar_start;
            if (arready && arvalid) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_start) begin
            araddr_q <= araddr;
        end
        if (arready && arvalid) begin
            rdata <= rd_data;
        end
    end

    assign rd_word = araddr_q[ADDR_LSB +: WORD_WIDTH];
    assign rresp   = RESP_OKAY;

    bvalid_held_until_bready: assert property (
        @(posedge aclk) disable iff (!aresetn)
        bvalid && !bready |=> bvalid
    );

    no_write_during_response: assert property (
        @(posedge aclk) disable iff (!aresetn)
        !(wr_en && bvalid)
    );

endmodule

`default_nettype wire

/* src/bw_token_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module bw_token_regs #(
    parameter int AXIL_ADDR_WIDTH  = 10,
    parameter int NUM_MASTERS      = 4,
    parameter int TOKEN_INT_WIDTH  = 16,
    parameter int TOKEN_FRAC_WIDTH = 8
) (
    input  logic                                             aclk,
    input  logic                                             aresetn,
    input  logic                                             wr_en,
    input  logic [AXIL_ADDR_WIDTH-mem_reg_pkg::ADDR_LSB-1:0] wr_word,
    input  logic [mem_reg_pkg::AXIL_DATA_WIDTH-1:0]          wr_data,
    input  logic [AXIL_ADDR_WIDTH-mem_reg_pkg::ADDR_LSB-1:0] rd_word,
    output logic [mem_reg_pkg::AXIL_DATA_WIDTH-1:0]          rd_token_data,
    output logic [NUM_MASTERS*2*(TOKEN_INT_WIDTH+TOKEN_FRAC_WIDTH+1)-1:0] bw_throt_regs
);
    import mem_reg_pkg::*;

    localparam int WORD_WIDTH  = AXIL_ADDR_WIDTH - ADDR_LSB;
    localparam int INIT_W      = TOKEN_INT_WIDTH;
    localparam int UPD_W       = TOKEN_FRAC_WIDTH + 1;
    localparam int FIELD_W     = 2 * (INIT_W + UPD_W);
    // Bank stride is a power of two so the master is the low word bits
    localparam int BANK_WORDS  = 2 ** $clog2(NUM_MASTERS);
    localparam int TOKEN_WORDS = NUM_TOKEN_BANKS * BANK_WORDS;
    localparam int MSEL_W      = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;

    // Index 0 is the write direction, 1 the read direction
    logic [INIT_W-1:0] init_tok [2][NUM_MASTERS];
    logic [UPD_W-1:0]  upd_tok  [2][NUM_MASTERS];

    logic [1:0]        wr_bank;
    logic [MSEL_W-1:0] wr_mst;
    logic [1:0]        rd_bank;
    logic [MSEL_W-1:0] rd_mst;

    // Inside the token area and on a populated master slot
    function automatic logic token_hit(input logic [WORD_WIDTH-1:0] word);
        return (int'(word) < TOKEN_WORDS) && ((int'(word) % BANK_WORDS) < NUM_MASTERS);
    endfunction

    assign wr_bank = 2'(int'(wr_word) / BANK_WORDS);
    assign wr_mst  = MSEL_W'(int'(wr_word) % BANK_WORDS);
    assign rd_bank = 2'(int'(rd_word) / BANK_WORDS);
    assign rd_mst  = MSEL_W'(int'(rd_word) % BANK_WORDS);

    // Bank bit 1 selects update over init, bit 0 read over write
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int d = 0; d < 2; d++) begin
                for (int m = 0; m < NUM_MASTERS; m++) begin
                    init_tok[d][m] <= '0;
                    upd_tok[d][m]  <= '0;
                end
            end
        end else if (wr_en && token_hit(wr_word)) begin
            if (wr_bank[1]) begin
                upd_tok[wr_bank[0]][wr_mst] <= wr_data[UPD_W-1:0];
            end else begin
                init_tok[wr_bank[0]][wr_mst] <= wr_data[INIT_W-1:0];
            end
        end
    end

    always_comb begin
        rd_token_data = '0;
        if (token_hit(rd_word)) begin
            if (rd_bank[1]) begin
                rd_token_data = AXIL_DATA_WIDTH'(upd_tok[rd_bank[0]][rd_mst]);
            end else begin
                rd_token_data = AXIL_DATA_WIDTH'(init_tok[rd_bank[0]][rd_mst]);
            end
        end
    end

    // Throttler field per master, read update on top down to write init
    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_pack
        assign bw_throt_regs[m*FIELD_W +: FIELD_W] = {
            upd_tok[1][m], init_tok[1][m], upd_tok[0][m], init_tok[0][m]
        };
    end

endmodule

`default_nettype wire

/* src/decouple_ctrl_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module decouple_ctrl_regs #(
    parameter int AXIL_ADDR_WIDTH  = 10,
    parameter int NUM_MASTERS      = 4,
    parameter int TOKEN_INT_WIDTH  = 16,
    parameter int TOKEN_FRAC_WIDTH = 8,
    parameter int UTIL_COUNT_WIDTH = 10
) (
    input  logic                                             aclk,
    input  logic                                             aresetn,
    input  logic                                             wr_en,
    input  logic [AXIL_ADDR_WIDTH-mem_reg_pkg::ADDR_LSB-1:0] wr_word,
    input  logic [mem_reg_pkg::AXIL_DATA_WIDTH-1:0]          wr_data,
    input  logic [AXIL_ADDR_WIDTH-mem_reg_pkg::ADDR_LSB-1:0] rd_word,
    output logic [mem_reg_pkg::AXIL_DATA_WIDTH-1:0]          rd_ctrl_data,

    output logic [NUM_MASTERS-1:0]                           decouple,
    input  logic [NUM_MASTERS-1:0]                           decouple_done,
    input  logic [mem_reg_pkg::DEC_STATUS_WIDTH*NUM_MASTERS-1:0] decouple_status,
    output logic [NUM_MASTERS-1:0]                           timeout_error_clear,
    input  logic [mem_reg_pkg::TIMEOUT_STATUS_WIDTH*NUM_MASTERS-1:0] timeout_status,
    input  logic [UTIL_COUNT_WIDTH:0]                        utilization
);
    import mem_reg_pkg::*;

    // Control words follow the four token banks
    localparam int CTRL_BASE = NUM_TOKEN_BANKS * (2 ** $clog2(NUM_MASTERS));
    localparam int CTRL_LAST = CTRL_BASE + int'(CTRL_UTIL);

    // Token area holds one token per word
    if (TOKEN_INT_WIDTH > AXIL_DATA_WIDTH || TOKEN_FRAC_WIDTH >= AXIL_DATA_WIDTH) begin : g_chk
        $error("Token width exceeds the bus word");
    end

    logic      wr_hit;
    logic      rd_hit;
    ctrl_reg_e wr_reg;
    ctrl_reg_e rd_reg;

    assign wr_hit = (int'(wr_word) >= CTRL_BASE) && (int'(wr_word) <= CTRL_LAST);
    assign rd_hit = (int'(rd_word) >= CTRL_BASE) && (int'(rd_word) <= CTRL_LAST);
    assign wr_reg = ctrl_reg_e'(3'(int'(wr_word) - CTRL_BASE));
    assign rd_reg = ctrl_reg_e'(3'(int'(rd_word) - CTRL_BASE));

    // Clear pulse drops back on the edge after the write
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            decouple            <= '0;
            timeout_error_clear <= '0;
        end else begin
            timeout_error_clear <= '0;
            if (wr_en && wr_hit) begin
                case (wr_reg)
                    CTRL_DEC_DO:     decouple            <= wr_data[NUM_MASTERS-1:0];
                    CTRL_TIME_CLEAR: timeout_error_clear <= wr_data[NUM_MASTERS-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Status words are read straight from the inputs
    always_comb begin
        rd_ctrl_data = '0;
        if (rd_hit) begin
            case (rd_reg)
                CTRL_DEC_STATUS:  rd_ctrl_data = AXIL_DATA_WIDTH'(decouple_status);
                CTRL_DEC_DO:      rd_ctrl_data = AXIL_DATA_WIDTH'(decouple);
                CTRL_DEC_DONE:    rd_ctrl_data = AXIL_DATA_WIDTH'(decouple_done);
                CTRL_TIME_STATUS: rd_ctrl_data = AXIL_DATA_WIDTH'(timeout_status);
                CTRL_UTIL:        rd_ctrl_data = AXIL_DATA_WIDTH'(utilization);
                // Clear word is write only
                default:          rd_ctrl_data = '0;
            endcase
        end
    end

    clear_pulse_single_cycle: assert property (
        @(posedge aclk) disable iff (!aresetn)
        (timeout_error_clear != '0) |=> (timeout_error_clear == '0)
    );

endmodule

`default_nettype wire

/* src/mem_reg_file_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_reg_file_top #(
    parameter int AXIL_ADDR_WIDTH  = 10,
    parameter int NUM_MASTERS      = 4,
    parameter int TOKEN_INT_WIDTH  = 16,
    parameter int TOKEN_FRAC_WIDTH = 8,
    parameter int UTIL_COUNT_WIDTH = 10
) (
    input  logic                                       aclk,
    input  logic                                       aresetn,

    input  logic [AXIL_ADDR_WIDTH-1:0]                 awaddr,
    input  logic                                       awvalid,
    output logic                                       awready,
    input  logic [mem_reg_pkg::AXIL_DATA_WIDTH-1:0]    wdata,
    input  logic                                       wvalid,
    output logic                                       wready,
    output logic                                       bvalid,
    output logic [1:0]                                 bresp,
    input  logic                                       bready,
    input  logic [AXIL_ADDR_WIDTH-1:0]                 araddr,
    input  logic                                       arvalid,
    output logic                                       arready,
    output logic                                       rvalid,
    output logic [1:0]                                 rresp,
    output logic [mem_reg_pkg::AXIL_DATA_WIDTH-1:0]    rdata,
    input  logic                                       rready,

    output logic [NUM_MASTERS-1:0]                     decouple,
    input  logic [NUM_MASTERS-1:0]                     decouple_done,
    input  logic [mem_reg_pkg::DEC_STATUS_WIDTH*NUM_MASTERS-1:0] decouple_status,
    output logic [NUM_MASTERS-1:0]                     timeout_error_clear,
    input  logic [mem_reg_pkg::TIMEOUT_STATUS_WIDTH*NUM_MASTERS-1:0] timeout_status,
    input  logic [UTIL_COUNT_WIDTH:0]                  utilization,
    output logic [NUM_MASTERS*2*(TOKEN_INT_WIDTH+TOKEN_FRAC_WIDTH+1)-1:0] bw_throt_regs
);
    import mem_reg_pkg::*;

    localparam int WORD_WIDTH = AXIL_ADDR_WIDTH - ADDR_LSB;

    logic                       wr_en;
    logic [WORD_WIDTH-1:0]      wr_word;
    logic [AXIL_DATA_WIDTH-1:0] wr_data;
    logic [WORD_WIDTH-1:0]      rd_word;
    logic [AXIL_DATA_WIDTH-1:0] rd_data;
    logic [AXIL_DATA_WIDTH-1:0] rd_token_data;
    logic [AXIL_DATA_WIDTH-1:0] rd_ctrl_data;

    axil_slave_port #(
        .AXIL_ADDR_WIDTH (AXIL_ADDR_WIDTH)
    ) port_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bresp   (bresp),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rvalid  (rvalid),
        .rresp   (rresp),
        .rdata   (rdata),
        .rready  (rready),
        .wr_en   (wr_en),
        .wr_word (wr_word),
        .wr_data (wr_data),
        .rd_word (rd_word),
        .rd_data (rd_data)
    );

    bw_token_regs #(
        .AXIL_ADDR_WIDTH  (AXIL_ADDR_WIDTH),
        .NUM_MASTERS      (NUM_MASTERS),
        .TOKEN_INT_WIDTH  (TOKEN_INT_WIDTH),
        .TOKEN_FRAC_WIDTH (TOKEN_FRAC_WIDTH)
    ) token_i (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .wr_en         (wr_en),
        .wr_word       (wr_word),
        .wr_data       (wr_data),
        .rd_word       (rd_word),
        .rd_token_data (rd_token_data),
        .bw_throt_regs (bw_throt_regs)
    );

    decouple_ctrl_regs #(
        .AXIL_ADDR_WIDTH  (AXIL_ADDR_WIDTH),
        .NUM_MASTERS      (NUM_MASTERS),
        .TOKEN_INT_WIDTH  (TOKEN_INT_WIDTH),
        .TOKEN_FRAC_WIDTH (TOKEN_FRAC_WIDTH),
        .UTIL_COUNT_WIDTH (UTIL_COUNT_WIDTH)
    ) ctrl_i (
        .aclk                (aclk),
        .aresetn             (aresetn),
        .wr_en               (wr_en),
        .wr_word             (wr_word),
        .wr_data             (wr_data),
        .rd_word             (rd_word),
        .rd_ctrl_data        (rd_ctrl_data),
        .decouple            (decouple),
        .decouple_done       (decouple_done),
        .decouple_status     (decouple_status),
        .timeout_error_clear (timeout_error_clear),
        .timeout_status      (timeout_status),
        .utilization         (utilization)
    );

    // Each block drives zero outside its own address area
    assign rd_data = rd_token_data | rd_ctrl_data;

endmodule

`default_nettype wire

/* src/mem_reg_pkg.sv */
`default_nettype none

package mem_reg_pkg;

    // Bus geometry
    localparam int AXIL_DATA_WIDTH = 32;
    localparam int ADDR_LSB        = 2;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Per-master status field widths
    localparam int DEC_STATUS_WIDTH     = 5;
    localparam int TIMEOUT_STATUS_WIDTH = 3;

    // Write init, read init, write update, read update
    localparam int NUM_TOKEN_BANKS = 4;

    // Word offsets of the control registers above the token area
    typedef enum logic [2:0] {
        CTRL_DEC_STATUS  = 3'd0,
        CTRL_DEC_DO      = 3'd1,
        CTRL_DEC_DONE    = 3'd2,
        CTRL_TIME_STATUS = 3'd3,
        CTRL_TIME_CLEAR  = 3'd4,
        CTRL_UTIL        = 3'd5
    } ctrl_reg_e;

    // AXI-Lite write channel FSM
    typedef enum logic [1:0] {
        WR_IDLE   = 2'd0,
        WR_ACCEPT = 2'd1,
        WR_RESP   = 2'd2
    } wr_state_e;

endpackage

`default_nettype wire

/* verification/mem_reg_file_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_reg_file_tb;
    import mem_reg_pkg::*;

    localparam int AXIL_ADDR_WIDTH  = 10;
    localparam int NUM_MASTERS      = 4;
    localparam int TOKEN_INT_WIDTH  = 16;
    localparam int TOKEN_FRAC_WIDTH = 8;
    localparam int UTIL_COUNT_WIDTH = 10;

    localparam int INIT_W      = TOKEN_INT_WIDTH;
    localparam int UPD_W       = TOKEN_FRAC_WIDTH + 1;
    localparam int FIELD_W     = 2 * (INIT_W + UPD_W);
    localparam int THROT_W     = NUM_MASTERS * FIELD_W;
    localparam int BANK_WORDS  = 2 ** $clog2(NUM_MASTERS);
    localparam int TOKEN_WORDS = NUM_TOKEN_BANKS * BANK_WORDS;
    localparam int CTRL_BASE   = TOKEN_WORDS;
    localparam int MAX_WORD    = 2 ** (AXIL_ADDR_WIDTH - ADDR_LSB) - 1;
    localparam int DS_W        = DEC_STATUS_WIDTH * NUM_MASTERS;
    localparam int TS_W        = TIMEOUT_STATUS_WIDTH * NUM_MASTERS;
    localparam int UT_W        = UTIL_COUNT_WIDTH + 1;
    // 400 transactions at up to 20 cycles each
    localparam int TIMEOUT_CYCLES = 400 * 20;

    localparam logic [AXIL_DATA_WIDTH-1:0] INIT_MASK = AXIL_DATA_WIDTH'((64'd1 << INIT_W) - 1);
    localparam logic [AXIL_DATA_WIDTH-1:0] UPD_MASK  = AXIL_DATA_WIDTH'((64'd1 << UPD_W) - 1);

    logic                       aclk;
    logic                       aresetn;
    logic [AXIL_ADDR_WIDTH-1:0] awaddr;
    logic                       awvalid;
    logic                       awready;
    logic [AXIL_DATA_WIDTH-1:0] wdata;
    logic                       wvalid;
    logic                       wready;
    logic                       bvalid;
    logic [1:0]                 bresp;
    logic                       bready;
    logic [AXIL_ADDR_WIDTH-1:0] araddr;
    logic                       arvalid;
    logic                       arready;
    logic                       rvalid;
    logic [1:0]                 rresp;
    logic [AXIL_DATA_WIDTH-1:0] rdata;
    logic                       rready;
    logic [NUM_MASTERS-1:0]     decouple;
    logic [NUM_MASTERS-1:0]     decouple_done;
    logic [DS_W-1:0]            decouple_status;
    logic [NUM_MASTERS-1:0]     timeout_error_clear;
    logic [TS_W-1:0]            timeout_status;
    logic [UT_W-1:0]            utilization;
    logic [THROT_W-1:0]         bw_throt_regs;

    // Reference model state
    logic [AXIL_DATA_WIDTH-1:0] tok_model [TOKEN_WORDS];
    logic [NUM_MASTERS-1:0]     dec_model;
    logic [NUM_MASTERS-1:0]     clr_at_write;
    logic [NUM_MASTERS-1:0]     clr_after;

    int checks      = 0;
    int errors      = 0;
    int test_errors = 0;
    int cycle_count = 0;

    mem_reg_file_top dut_i (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: a bus handshake did not complete within %0d cycles", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [255:0] got,
                                 input logic [255:0] want);
        checks++;
        assert (got === want) else begin
            errors++;
            test_errors++;
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, want);
        end
    endtask

    task automatic confirm(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            test_errors++;
            $display("Failure: %s", what);
        end
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            $display("Test %s: PASS", name);
        end else begin
            $display("Test %s: FAIL with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic write_word(input int word, input logic [AXIL_DATA_WIDTH-1:0] data);
        int stall;
        awaddr  = AXIL_ADDR_WIDTH'(word << ADDR_LSB);
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge aclk);
        while (!awready) begin
            @(negedge aclk);
        end
        confirm(wready, "wready low in the address ready cycle");
        // Register updates on the edge that closes the ready cycle
        @(negedge aclk);
        clr_at_write = timeout_error_clear;
        confirm(bvalid, "no write response after the ready cycle");
        compare_value("bresp", 256'(bresp), 256'(RESP_OKAY));
        // Valids stay up during the stall, a second write must not be taken
        stall = int'($urandom_range(0, 5));
        for (int i = 0; i < stall; i++) begin
            @(negedge aclk);
            if (i == 0) begin
                clr_after = timeout_error_clear;
            end
            confirm(bvalid && !awready && !wready,
                    "write channel moved while bready was low");
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(negedge aclk);
        if (stall == 0) begin
            clr_after = timeout_error_clear;
        end
        bready = 1'b0;
        confirm(!bvalid, "bvalid still high after bready");
    endtask

    task automatic read_word(input int word, output logic [AXIL_DATA_WIDTH-1:0] data);
        int stall;
        araddr  = AXIL_ADDR_WIDTH'(word << ADDR_LSB);
        arvalid = 1'b1;
        @(negedge aclk);
        while (!arready) begin
            @(negedge aclk);
        end
        @(negedge aclk);
        confirm(rvalid, "no read data after the address handshake");
        compare_value("rresp", 256'(rresp), 256'(RESP_OKAY));
        data  = rdata;
        // Address stays offered during the stall, no second read may start
        stall = int'($urandom_range(0, 5));
        for (int i = 0; i < stall; i++) begin
            @(negedge aclk);
            confirm(rvalid && !arready, "read channel moved while rready was low");
            compare_value("rdata", 256'(rdata), 256'(data));
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        @(negedge aclk);
        rready = 1'b0;
        confirm(!rvalid, "rvalid still high after rready");
    endtask

    // Per master, from high to low: read update, read init, write update, write init
    function automatic logic [THROT_W-1:0] pack_throttle();
        logic [THROT_W-1:0] v;
        v = '0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            v[m*FIELD_W +: FIELD_W] = {
                tok_model[3*BANK_WORDS+m][UPD_W-1:0], tok_model[BANK_WORDS+m][INIT_W-1:0],
                tok_model[2*BANK_WORDS+m][UPD_W-1:0], tok_model[m][INIT_W-1:0]
            };
        end
        return v;
    endfunction

    task automatic drive_status();
        decouple_status = DS_W'($urandom());
        decouple_done   = NUM_MASTERS'($urandom());
        timeout_status  = TS_W'($urandom());
        utilization     = UT_W'($urandom());
    endtask

    // Model update for one token write, unused slots keep zero
    task automatic store_token(input int word, input logic [AXIL_DATA_WIDTH-1:0] data);
        if ((word % BANK_WORDS) < NUM_MASTERS) begin
            if ((word / BANK_WORDS) < 2) begin
                tok_model[word] = data & INIT_MASK;
            end else begin
                tok_model[word] = data & UPD_MASK;
            end
        end
    endtask

    initial begin
        logic [AXIL_DATA_WIDTH-1:0] data;
        logic [AXIL_DATA_WIDTH-1:0] rd;
        int                         word;

        void'($urandom(72));
        aresetn         = 1'b0;
        awaddr          = '0;
        awvalid         = 1'b0;
        wdata           = '0;
        wvalid          = 1'b0;
        bready          = 1'b0;
        araddr          = '0;
        arvalid         = 1'b0;
        rready          = 1'b0;
        decouple_done   = '0;
        decouple_status = '0;
        timeout_status  = '0;
        utilization     = '0;
        dec_model       = '0;
        for (int w = 0; w < TOKEN_WORDS; w++) begin
            tok_model[w] = '0;
        end

        repeat (5) @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);

        compare_value("awready", 256'(awready), 256'(0));
        compare_value("wready", 256'(wready), 256'(0));
        compare_value("arready", 256'(arready), 256'(0));
        compare_value("bvalid", 256'(bvalid), 256'(0));
        compare_value("rvalid", 256'(rvalid), 256'(0));
        compare_value("decouple", 256'(decouple), 256'(0));
        compare_value("timeout_error_clear", 256'(timeout_error_clear), 256'(0));
        compare_value("bw_throt_regs", 256'(bw_throt_regs), 256'(0));
        report_test("reset");

        for (int n = 0; n < 100; n++) begin
            word = int'($urandom_range(0, TOKEN_WORDS - 1));
            data = $urandom();
            write_word(word, data);
            store_token(word, data);
            compare_value("bw_throt_regs", 256'(bw_throt_regs), 256'(pack_throttle()));
        end
        for (int w = 0; w < TOKEN_WORDS; w++) begin
            read_word(w, rd);
            compare_value($sformatf("rdata word %0d", w), 256'(rd), 256'(tok_model[w]));
        end
        report_test("token banks");

        for (int n = 0; n < 10; n++) begin
            data = $urandom();
            write_word(CTRL_BASE + int'(CTRL_DEC_DO), data);
            dec_model = data[NUM_MASTERS-1:0];
            compare_value("decouple", 256'(decouple), 256'(dec_model));
            read_word(CTRL_BASE + int'(CTRL_DEC_DO), rd);
            compare_value("rdata decouple", 256'(rd), 256'(dec_model));
        end
        report_test("decouple request");

        for (int n = 0; n < 8; n++) begin
            data = $urandom();
            write_word(CTRL_BASE + int'(CTRL_TIME_CLEAR), data);
            compare_value("timeout_error_clear", 256'(clr_at_write),
                          256'(data[NUM_MASTERS-1:0]));
            compare_value("timeout_error_clear next", 256'(clr_after), 256'(0));
            compare_value("decouple", 256'(decouple), 256'(dec_model));
            read_word(CTRL_BASE + int'(CTRL_TIME_CLEAR), rd);
            compare_value("rdata time clear", 256'(rd), 256'(0));
        end
        report_test("timeout clear");

        for (int n = 0; n < 10; n++) begin
            drive_status();
            read_word(CTRL_BASE + int'(CTRL_DEC_STATUS), rd);
            compare_value("rdata decouple_status", 256'(rd), 256'(decouple_status));
            read_word(CTRL_BASE + int'(CTRL_DEC_DONE), rd);
            compare_value("rdata decouple_done", 256'(rd), 256'(decouple_done));
            read_word(CTRL_BASE + int'(CTRL_TIME_STATUS), rd);
            compare_value("rdata timeout_status", 256'(rd), 256'(timeout_status));
            read_word(CTRL_BASE + int'(CTRL_UTIL), rd);
            compare_value("rdata utilization", 256'(rd), 256'(utilization));
            // Anything above the control words is unmapped
            for (int k = 0; k < 2; k++) begin
                word = int'($urandom_range(CTRL_BASE + 6, MAX_WORD));
                read_word(word, rd);
                compare_value($sformatf("rdata word %0d", word), 256'(rd), 256'(0));
            end
        end
        report_test("status readback");

        // Every transaction stalls its response channel for a random time
        for (int n = 0; n < 20; n++) begin
            word = int'($urandom_range(0, TOKEN_WORDS - 1));
            data = $urandom();
            write_word(word, data);
            store_token(word, data);
            read_word(word, rd);
            compare_value($sformatf("rdata word %0d", word), 256'(rd), 256'(tok_model[word]));
        end
        compare_value("bw_throt_regs", 256'(bw_throt_regs), 256'(pack_throttle()));
        report_test("back-pressure");

        $display("Summary: %0d checks, %0d errors, %0d cycles", checks, errors, cycle_count);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
